//--- Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - csr_op_pkg.sv
  - csr_trap_pkg.sv
  - csr_access.sv
  - csr_regfile.sv
  - csr_timer.sv
  - csr_trap_ctrl.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_unit_tb.sv

//--- all.f
+incdir+.
csr_op_pkg.sv
csr_trap_pkg.sv
csr_access.sv
csr_regfile.sv
csr_timer.sv
csr_trap_ctrl.sv
csr_unit.sv
csr_unit_tb.sv

//--- csr_access.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_access (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  csr_op_pkg::csr_req_t req,
    input  logic [`CSR_DW-1:0]   old_data,
    output logic [`CSR_AW-1:0]   rd_addr,
    output csr_op_pkg::csr_wr_t  wr
);
    import csr_op_pkg::*;

    logic               is_write;
    logic [`CSR_DW-1:0] merged;

    assign rd_addr = req.addr;    // old value comes back as old_data
    assign merged  = (req.wdata & req.mask) | (old_data & ~req.mask);

    always_comb begin
        is_write = 1'b0;
        wr.data  = req.wdata;
        case (req.op)
            op_wr: begin
                is_write = 1'b1;
            end
            op_xchg: begin
                is_write = 1'b1;
                wr.data  = merged;    // set mask bits take wdata
            end
            default: begin
                is_write = 1'b0;
            end
        endcase
        wr.we   = is_write && !stall;
        wr.addr = req.addr;
    end

    // reads and bubbles must never touch the register file
    assert property (@(posedge clk) disable iff (reset)
        (req.op inside {op_rd, op_nop}) |-> !wr.we)
        else $error("write enable raised for a non-write opcode");

endmodule

//--- csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// csr numbers
`define CRMD_ADDR       14'h0
`define PRMD_ADDR       14'h1
`define ECFG_ADDR       14'h4
`define ESTAT_ADDR      14'h5
`define ERA_ADDR        14'h6
`define BADV_ADDR       14'h7
`define EENTRY_ADDR     14'hc
`define SAVE0_ADDR      14'h30
`define SAVE1_ADDR      14'h31
`define SAVE2_ADDR      14'h32
`define SAVE3_ADDR      14'h33
`define TID_ADDR        14'h40
`define TCFG_ADDR       14'h41
`define TVAL_ADDR       14'h42
`define TICLR_ADDR      14'h44

`define CSR_AW          14
`define CSR_DW          32
`define ECODE_W         6
`define INT_W           13

`define ECODE_LSB       16
`define ECODE_MSB       21
`define TI_BIT          11
`define CRMD_IE_BIT     2       // plv in 1:0, ie above it
`define TCFG_EN_BIT     0
`define TCFG_PER_BIT    1

`define CRMD_RESET      32'h8   // da set
`define CRMD_WMASK      32'h0000_01ff
`define ECFG_WMASK      32'h0000_1fff
`define ESTAT_WMASK     32'h0000_0003   // swi only

`endif

//--- csr_op_pkg.sv
`include "csr_macros.svh"

package csr_op_pkg;

    typedef enum logic [1:0] {
        op_nop,
        op_rd,
        op_wr,
        op_xchg
    } csr_op_t;

    // one csr instruction from execute
    typedef struct packed {
        csr_op_t            op;
        logic [`CSR_AW-1:0] addr;
        logic [`CSR_DW-1:0] wdata;
        logic [`CSR_DW-1:0] mask;
    } csr_req_t;

    // resolved write toward the register file
    typedef struct packed {
        logic               we;
        logic [`CSR_AW-1:0] addr;
        logic [`CSR_DW-1:0] data;
    } csr_wr_t;

endpackage

//--- csr_regfile.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`CSR_AW-1:0]       rd_addr,
    input  csr_op_pkg::csr_wr_t      wr,
    input  csr_trap_pkg::trap_evt_t  evt,
    input  logic [`CSR_DW-1:0]       tcfg,
    input  logic [`CSR_DW-1:0]       tval,
    input  logic                     ti,
    output logic [`CSR_DW-1:0]       rdata,
    output csr_trap_pkg::trap_view_t view,
    output logic                     tcfg_we,
    output logic                     ticlr_we,
    output logic [`CSR_DW-1:0]       wdata
);
    import csr_trap_pkg::*;

    logic [`CSR_DW-1:0] crmd;
    logic [`CSR_DW-1:0] prmd;
    logic [`CSR_DW-1:0] ecfg;
    logic [`CSR_DW-1:0] estat_q;   // swi and ecode with ti merged on read
    logic [`CSR_DW-1:0] estat_rd;
    logic [`CSR_DW-1:0] era;
    logic [`CSR_DW-1:0] badv;
    logic [`CSR_DW-1:0] eentry;
    logic [`CSR_DW-1:0] save0;
    logic [`CSR_DW-1:0] save1;
    logic [`CSR_DW-1:0] save2;
    logic [`CSR_DW-1:0] save3;
    logic [`CSR_DW-1:0] tid;
    logic               wr_en;
    logic               badv_upd;

    assign wr_en    = wr.we && !evt.enter && !evt.leave;  // trap beats write
    assign badv_upd = evt.ecode inside {ec_ale, ec_adef};

    // timer registers live in csr_timer
    assign tcfg_we  = wr_en && (wr.addr == `TCFG_ADDR);
    assign ticlr_we = wr_en && (wr.addr == `TICLR_ADDR);
    assign wdata    = wr.data;

    always_comb begin
        estat_rd          = estat_q;
        estat_rd[`TI_BIT] = ti;
    end

    always_comb begin
        case (rd_addr)
            `CRMD_ADDR:   rdata = crmd;
            `PRMD_ADDR:   rdata = prmd;
            `ECFG_ADDR:   rdata = ecfg;
            `ESTAT_ADDR:  rdata = estat_rd;
            `ERA_ADDR:    rdata = era;
            `BADV_ADDR:   rdata = badv;
            `EENTRY_ADDR: rdata = eentry;
            `SAVE0_ADDR:  rdata = save0;
            `SAVE1_ADDR:  rdata = save1;
            `SAVE2_ADDR:  rdata = save2;
            `SAVE3_ADDR:  rdata = save3;
            `TID_ADDR:    rdata = tid;
            `TCFG_ADDR:   rdata = tcfg;
            `TVAL_ADDR:   rdata = tval;
            default:      rdata = '0;   // ticlr and unimplemented
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd    <= `CRMD_RESET;
            prmd    <= '0;
            ecfg    <= '0;
            estat_q <= '0;
            era     <= '0;
            badv    <= '0;
            eentry  <= '0;
            save0   <= '0;
            save1   <= '0;
            save2   <= '0;
            save3   <= '0;
            tid     <= '0;
        end else if (evt.enter) begin
            prmd[`CRMD_IE_BIT:0] <= crmd[`CRMD_IE_BIT:0];
            crmd[`CRMD_IE_BIT:0] <= '0;   // kernel mode with ints off
            era                  <= evt.pc;
            estat_q[`ECODE_MSB:`ECODE_LSB] <= evt.ecode;
            if (badv_upd) begin
                badv <= evt.badv;
            end
        end else if (evt.leave) begin
            crmd[`CRMD_IE_BIT:0] <= prmd[`CRMD_IE_BIT:0];
        end else if (wr_en) begin
            case (wr.addr)
                `CRMD_ADDR:   crmd    <= wr.data & `CRMD_WMASK;
                `PRMD_ADDR:   prmd    <= wr.data;
                `ECFG_ADDR:   ecfg    <= wr.data & `ECFG_WMASK;
                `ESTAT_ADDR:  estat_q <= (estat_q & ~`ESTAT_WMASK) | (wr.data & `ESTAT_WMASK);
                `ERA_ADDR:    era     <= wr.data;
                `BADV_ADDR:   badv    <= wr.data;
                `EENTRY_ADDR: eentry  <= wr.data;
                `SAVE0_ADDR:  save0   <= wr.data;
                `SAVE1_ADDR:  save1   <= wr.data;
                `SAVE2_ADDR:  save2   <= wr.data;
                `SAVE3_ADDR:  save3   <= wr.data;
                `TID_ADDR:    tid     <= wr.data;
                default: begin
                end
            endcase
        end
    end

    assign view.ie        = crmd[`CRMD_IE_BIT];
    assign view.int_lines = estat_rd[`INT_W-1:0] & ecfg[`INT_W-1:0];
    assign view.eentry    = eentry;
    assign view.era       = era;

    // trap control must pick one event per cycle
    assert property (@(posedge clk) disable iff (reset) !(evt.enter && evt.leave))
        else $error("trap entry and ertn in the same cycle");

endmodule

//--- csr_timer.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_timer (
    input  logic               clk,
    input  logic               reset,
    input  logic               tcfg_we,
    input  logic               ticlr_we,
    input  logic [`CSR_DW-1:0] wdata,
    output logic [`CSR_DW-1:0] tcfg,
    output logic [`CSR_DW-1:0] tval,
    output logic               ti
);
    logic [`CSR_DW-1:0] init_val;
    logic               counting;
    logic               expire;

    assign init_val = {tcfg[`CSR_DW-1:2], 2'b00};
    assign counting = tcfg[`TCFG_EN_BIT] && (tval != '0);
    assign expire   = counting && (tval == `CSR_DW'(1));   // last step to zero

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end else begin
            if (tcfg_we) begin
                tcfg <= wdata;
                tval <= {wdata[`CSR_DW-1:2], 2'b00};
            end else if (expire) begin
                tval <= tcfg[`TCFG_PER_BIT] ? init_val : '0;   // one-shot parks at 0
            end else if (counting) begin
                tval <= tval - 1'b1;
            end
            if (expire) begin
                ti <= 1'b1;
            end else if (ticlr_we && wdata[0]) begin
                ti <= 1'b0;
            end
        end
    end

endmodule

//--- csr_trap_ctrl.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_trap_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  csr_trap_pkg::except_req_t exc,
    input  logic                      ertn,
    input  csr_trap_pkg::trap_view_t  view,
    output csr_trap_pkg::trap_evt_t   evt,
    output csr_trap_pkg::redirect_t   redirect
);
    import csr_trap_pkg::*;

    typedef enum logic [1:0] {
        sel_none,
        sel_exc,
        sel_int,
        sel_ertn
    } trap_sel_t;

    trap_sel_t sel;
    logic      int_pending;

    assign int_pending = view.ie && (view.int_lines != '0);

    always_comb begin
        if (stall)
            sel = sel_none;
        else if (exc.valid)
            sel = sel_exc;
        else if (int_pending)
            sel = sel_int;
        else if (ertn)
            sel = sel_ertn;
        else
            sel = sel_none;
    end

    always_comb begin
        evt      = '0;
        redirect = '0;
        case (sel)
            sel_exc: begin
                evt.enter      = 1'b1;
                evt.ecode      = exc.ecode;
                evt.pc         = exc.pc;
                evt.badv       = exc.badv;
                redirect.valid = 1'b1;
                redirect.pc    = view.eentry;
            end
            sel_int: begin
                evt.enter      = 1'b1;
                evt.ecode      = ec_int;
                evt.pc         = exc.pc;    // resume point of the interrupted instr
                redirect.valid = 1'b1;
                redirect.pc    = view.eentry;
            end
            sel_ertn: begin
                evt.leave      = 1'b1;
                redirect.valid = 1'b1;
                redirect.pc    = view.era;
            end
            default: begin
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) redirect.valid |-> !stall)
        else $error("redirect raised while stalled");

    // entry must mask interrupts right away, or the handler is re-entered
    assert property (@(posedge clk) disable iff (reset) evt.enter |=> !view.ie)
        else $error("interrupts still enabled after trap entry");

endmodule

//--- csr_trap_pkg.sv
`include "csr_macros.svh"

package csr_trap_pkg;

    typedef enum logic [`ECODE_W-1:0] {
        ec_int  = 6'h00,
        ec_adef = 6'h08,
        ec_ale  = 6'h09,
        ec_sys  = 6'h0b,
        ec_brk  = 6'h0c,
        ec_ine  = 6'h0d
    } ecode_t;

    typedef struct packed {
        logic               valid;
        ecode_t             ecode;
        logic [`CSR_DW-1:0] pc;
        logic [`CSR_DW-1:0] badv;
    } except_req_t;

    typedef struct packed {
        logic               enter;
        logic               leave;
        ecode_t             ecode;
        logic [`CSR_DW-1:0] pc;
        logic [`CSR_DW-1:0] badv;
    } trap_evt_t;

    typedef struct packed {
        logic               ie;
        logic [`INT_W-1:0]  int_lines;  // estat & ecfg
        logic [`CSR_DW-1:0] eentry;
        logic [`CSR_DW-1:0] era;
    } trap_view_t;

    typedef struct packed {
        logic               valid;
        logic [`CSR_DW-1:0] pc;
    } redirect_t;

endpackage

//--- csr_unit.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  csr_op_pkg::csr_req_t      req,
    output logic [`CSR_DW-1:0]        rdata,
    input  csr_trap_pkg::except_req_t exc,
    input  logic                      ertn,
    output csr_trap_pkg::redirect_t   redirect
);
    import csr_op_pkg::*;
    import csr_trap_pkg::*;

    logic [`CSR_AW-1:0] rd_addr;
    csr_wr_t            wr;
    trap_evt_t          evt;
    trap_view_t         view;
    logic               tcfg_we;
    logic               ticlr_we;
    logic [`CSR_DW-1:0] wdata;
    logic [`CSR_DW-1:0] tcfg;
    logic [`CSR_DW-1:0] tval;
    logic               ti;

    csr_access u_access (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .req      (req),
        .old_data (rdata),      // read port doubles as the xchg source
        .rd_addr  (rd_addr),
        .wr       (wr)
    );

    csr_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_addr  (rd_addr),
        .wr       (wr),
        .evt      (evt),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti       (ti),
        .rdata    (rdata),
        .view     (view),
        .tcfg_we  (tcfg_we),
        .ticlr_we (ticlr_we),
        .wdata    (wdata)
    );

    csr_timer u_timer (
        .clk      (clk),
        .reset    (reset),
        .tcfg_we  (tcfg_we),
        .ticlr_we (ticlr_we),
        .wdata    (wdata),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti       (ti)
    );

    csr_trap_ctrl u_trap (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .exc      (exc),
        .ertn     (ertn),
        .view     (view),
        .evt      (evt),
        .redirect (redirect)
    );

endmodule

//--- csr_unit_tb.sv
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_unit_tb;
    import csr_op_pkg::*;
    import csr_trap_pkg::*;

    localparam int num_tests       = 5;
    localparam int cycles_per_test = 400;
    localparam int watchdog_cycles = num_tests * cycles_per_test;

    logic        clk;
    logic        reset;
    logic        stall;
    csr_req_t    req;
    logic [31:0] rdata;
    except_req_t exc;
    logic        ertn;
    redirect_t   redirect;

    integer seed = 37;
    int     err_cnt = 0;
    int     err_at_start = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;

    // shadow registers
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_ecfg;
    logic [31:0] m_estat;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic [31:0] m_tval;
    logic [31:0] m_save [4];
    logic        m_ti;

    logic [31:0] exp_rdata;
    logic [31:0] new_data;
    logic        int_pending;
    logic        take_exc;
    logic        take_int;
    logic        take_ertn;
    logic        exp_valid;
    logic [31:0] exp_pc;
    logic        do_write;

    logic [13:0] plain_addrs [6] = '{`SAVE0_ADDR, `SAVE1_ADDR, `SAVE2_ADDR,
                                     `SAVE3_ADDR, `EENTRY_ADDR, `ERA_ADDR};

    csr_unit dut (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .req      (req),
        .rdata    (rdata),
        .exc      (exc),
        .ertn     (ertn),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] model_read(input logic [13:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            `CRMD_ADDR:   v = m_crmd;
            `PRMD_ADDR:   v = m_prmd;
            `ECFG_ADDR:   v = m_ecfg;
            `ESTAT_ADDR: begin
                v          = m_estat;
                v[`TI_BIT] = m_ti;
            end
            `ERA_ADDR:    v = m_era;
            `BADV_ADDR:   v = m_badv;
            `EENTRY_ADDR: v = m_eentry;
            `SAVE0_ADDR:  v = m_save[0];
            `SAVE1_ADDR:  v = m_save[1];
            `SAVE2_ADDR:  v = m_save[2];
            `SAVE3_ADDR:  v = m_save[3];
            `TID_ADDR:    v = m_tid;
            `TCFG_ADDR:   v = m_tcfg;
            `TVAL_ADDR:   v = m_tval;
            default:      v = '0;
        endcase
        return v;
    endfunction

    always_comb begin
        exp_rdata   = model_read(req.addr);
        new_data    = (req.op == op_xchg) ?
                      ((req.wdata & req.mask) | (exp_rdata & ~req.mask)) : req.wdata;
        int_pending = m_crmd[2] &&
                      (({m_estat[12], m_ti, m_estat[10:0]} & m_ecfg[12:0]) != '0);
        take_exc    = !stall && exc.valid;
        take_int    = !stall && !exc.valid && int_pending;
        take_ertn   = !stall && !exc.valid && !int_pending && ertn;
        exp_valid   = take_exc || take_int || take_ertn;
        exp_pc      = take_ertn ? m_era : m_eentry;
        do_write    = !stall && !exp_valid && (req.op inside {op_wr, op_xchg});
    end

    always @(posedge clk) begin
        if (reset) begin
            m_crmd   <= 32'h8;
            m_prmd   <= '0;
            m_ecfg   <= '0;
            m_estat  <= '0;
            m_era    <= '0;
            m_badv   <= '0;
            m_eentry <= '0;
            m_tid    <= '0;
            m_tcfg   <= '0;
            m_tval   <= '0;
            m_save   <= '{default: '0};
            m_ti     <= 1'b0;
        end else begin
            if (do_write && req.addr == `TCFG_ADDR) begin
                m_tcfg <= new_data;
                m_tval <= {new_data[31:2], 2'b00};
            end else if (m_tcfg[0] && m_tval == 32'd1) begin
                m_tval <= m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : '0;
            end else if (m_tcfg[0] && m_tval != '0) begin
                m_tval <= m_tval - 32'd1;
            end
            if (m_tcfg[0] && m_tval == 32'd1)
                m_ti <= 1'b1;
            else if (do_write && req.addr == `TICLR_ADDR && new_data[0])
                m_ti <= 1'b0;
            if (take_exc || take_int) begin
                m_prmd[2:0]  <= m_crmd[2:0];
                m_crmd[2:0]  <= 3'b000;
                m_era        <= exc.pc;
                m_estat[`ECODE_MSB:`ECODE_LSB] <= take_exc ? exc.ecode : 6'h00;
                if (take_exc && exc.ecode inside {ec_ale, ec_adef})
                    m_badv <= exc.badv;
            end else if (take_ertn) begin
                m_crmd[2:0] <= m_prmd[2:0];
            end else if (do_write) begin
                case (req.addr)
                    `CRMD_ADDR:   m_crmd       <= new_data & 32'h1ff;
                    `PRMD_ADDR:   m_prmd       <= new_data;
                    `ECFG_ADDR:   m_ecfg       <= new_data & 32'h1fff;
                    `ESTAT_ADDR:  m_estat[1:0] <= new_data[1:0];
                    `ERA_ADDR:    m_era        <= new_data;
                    `BADV_ADDR:   m_badv       <= new_data;
                    `EENTRY_ADDR: m_eentry     <= new_data;
                    `SAVE0_ADDR:  m_save[0]    <= new_data;
                    `SAVE1_ADDR:  m_save[1]    <= new_data;
                    `SAVE2_ADDR:  m_save[2]    <= new_data;
                    `SAVE3_ADDR:  m_save[3]    <= new_data;
                    `TID_ADDR:    m_tid        <= new_data;
                    default: begin
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) rdata == exp_rdata)
        else begin
            err_cnt++;
            $display("Mismatch at %0t: rdata %h at addr %h, expected %h", $time,
                     $sampled(rdata), $sampled(req.addr), $sampled(exp_rdata));
        end

    assert property (@(posedge clk) disable iff (reset)
        (redirect.valid == exp_valid) && (!exp_valid || redirect.pc == exp_pc))
        else begin
            err_cnt++;
            $display("Mismatch at %0t: redirect %b/%h, expected %b/%h", $time,
                     $sampled(redirect.valid), $sampled(redirect.pc),
                     $sampled(exp_valid), $sampled(exp_pc));
        end

    task automatic drive_cycle(input csr_op_t op, input logic [13:0] addr,
                               input logic [31:0] data, input logic [31:0] mask,
                               input logic stl);
        @(negedge clk);
        req.op    = op;
        req.addr  = addr;
        req.wdata = data;
        req.mask  = mask;
        stall     = stl;
        exc       = '0;
        ertn      = 1'b0;
    endtask

    task automatic read_reg(input logic [13:0] addr);
        drive_cycle(op_rd, addr, '0, '0, 1'b0);
    endtask

    task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
        drive_cycle(op_wr, addr, data, '0, 1'b0);
    endtask

    task automatic raise_exception(input ecode_t ec, input logic [31:0] pc,
                                   input logic [31:0] badv);
        drive_cycle(op_nop, '0, '0, '0, 1'b0);
        exc.valid = 1'b1;
        exc.ecode = ec;
        exc.pc    = pc;
        exc.badv  = badv;
    endtask

    task automatic return_from_trap();
        drive_cycle(op_nop, '0, '0, '0, 1'b0);
        ertn = 1'b1;
    endtask

    task automatic wait_for_redirect(input int limit, output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = redirect.valid;    // inputs idle, state settled
        end
    endtask

    task automatic end_test(input string name);
        drive_cycle(op_nop, '0, '0, '0, 1'b0);
        if (err_cnt == err_at_start) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
        err_at_start = err_cnt;
    endtask

    initial begin
        #(watchdog_cycles * 100);
        $display("watchdog expired: run did not finish within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] pc;
        bit          seen;
        int          i;
        reset = 1'b1;
        stall = 1'b0;
        req   = '0;
        exc   = '0;
        ertn  = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        for (i = 0; i < 6; i++) begin
            write_reg(plain_addrs[i], $random(seed));
            read_reg(plain_addrs[i]);
        end
        write_reg(`ECFG_ADDR, $random(seed));
        read_reg(`ECFG_ADDR);
        write_reg(`ECFG_ADDR, '0);
        write_reg(`ESTAT_ADDR, $random(seed));
        read_reg(`ESTAT_ADDR);
        write_reg(`ESTAT_ADDR, '0);
        write_reg(`CRMD_ADDR, $random(seed));
        read_reg(`CRMD_ADDR);
        write_reg(`CRMD_ADDR, 32'h8);
        end_test("1 csrwr and csrrd readback");

        for (i = 0; i < 4; i++) begin
            v = $random(seed);
            drive_cycle(op_xchg, plain_addrs[i], v, $random(seed), 1'b0);
            read_reg(plain_addrs[i]);
        end
        end_test("2 csrxchg mask merge");

        write_reg(14'h10, $random(seed));    // tlbidx is not implemented
        read_reg(14'h10);
        write_reg(14'h180, $random(seed));   // dmw0
        read_reg(14'h180);
        drive_cycle(op_wr, `SAVE0_ADDR, $random(seed), '0, 1'b1);
        read_reg(`SAVE0_ADDR);
        end_test("3 unimplemented and stalled writes");

        write_reg(`CRMD_ADDR, 32'hf);        // plv 3, ie on
        write_reg(`EENTRY_ADDR, $random(seed) & 32'hffff_ffc0);
        pc = $random(seed);
        raise_exception(ec_ale, pc, $random(seed));
        read_reg(`ERA_ADDR);
        read_reg(`BADV_ADDR);
        read_reg(`ESTAT_ADDR);
        read_reg(`PRMD_ADDR);
        read_reg(`CRMD_ADDR);
        return_from_trap();
        read_reg(`CRMD_ADDR);
        end_test("4 exception entry and ertn");

        write_reg(`ECFG_ADDR, 32'h1 << `TI_BIT);
        write_reg(`CRMD_ADDR, 32'hc);        // da, ie, plv 0
        write_reg(`TCFG_ADDR, 32'h9);        // one-shot, initial value 8
        drive_cycle(op_nop, '0, '0, '0, 1'b0);
        wait_for_redirect(64, seen);
        if (!seen) begin
            err_cnt++;
            $display("timer interrupt did not redirect within 64 cycles");
        end
        read_reg(`ESTAT_ADDR);
        read_reg(`TVAL_ADDR);
        write_reg(`TICLR_ADDR, 32'h1);
        read_reg(`ESTAT_ADDR);
        end_test("5 timer interrupt");

        $display("%0d tests ok, %0d tests failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
